// File: rtl/sd_cmd_pkg.sv
package sd_cmd_pkg;

  // Frame lengths in bits, start and end bits included
  localparam int CMD_FRAME_LEN = 48;
  localparam int RSP_SHORT_LEN = 48;
  localparam int RSP_LONG_LEN  = 136;
  localparam int TIMEOUT_W     = 16;

  typedef enum logic [5:0] {
    CMD_GO_IDLE          = 6'd0,
    CMD_ALL_SEND_CID     = 6'd2,
    CMD_SEND_RCA         = 6'd3,
    CMD_SELECT           = 6'd7,
    CMD_SEND_IF_COND     = 6'd8,
    CMD_SEND_CSD         = 6'd9,
    ACMD_SD_SEND_OP_COND = 6'd41,
    CMD_APP_CMD          = 6'd55
  } sd_cmd_e;

  typedef enum logic [1:0] {RSP_NONE, RSP_SHORT, RSP_SHORT_NOCRC, RSP_LONG} rsp_kind_e;

  typedef enum logic [2:0] {ERR_NONE, ERR_TIMEOUT, ERR_CRC, ERR_INDEX, ERR_END_BIT} sd_err_e;

  // Response kind per command index, unlisted indices get R1 style
  function automatic rsp_kind_e rsp_kind_of(input logic [5:0] idx);
    rsp_kind_e kind;
    case (idx)
      CMD_GO_IDLE:                    kind = RSP_NONE;
      CMD_ALL_SEND_CID, CMD_SEND_CSD: kind = RSP_LONG;
      ACMD_SD_SEND_OP_COND:           kind = RSP_SHORT_NOCRC;
      default:                        kind = RSP_SHORT;
    endcase
    return kind;
  endfunction

endpackage

// File: rtl/sd_crc_pkg.sv
package sd_crc_pkg;

  // x^7 + x^3 + 1
  localparam logic [6:0] CRC7_POLY = 7'h09;

  // One bit of the CRC7 LFSR, data fed MSB first
  function automatic logic [6:0] crc7_step(
    input logic [6:0] crc,
    input logic       din
  );
    logic       fb;
    logic [6:0] nxt;
    fb  = crc[6] ^ din;
    nxt = {crc[5:0], 1'b0};
    if (fb) begin
      nxt = nxt ^ CRC7_POLY;
    end
    return nxt;
  endfunction

endpackage

// File: rtl/sd_cmd_if.sv
`timescale 1ns/1ns

interface sd_cmd_if import sd_cmd_pkg::*; ();

  logic           cmd_stb;
  // 01, index, argument
  logic [39:0]    cmd_body;
  rsp_kind_e      rsp_kind;
  logic           tx_done;
  logic           rsp_done;
  sd_err_e        rsp_err;
  logic [135:0]   rsp_data;

  modport layer (
    output cmd_stb, cmd_body, rsp_kind,
    input  rsp_done, rsp_err, rsp_data
  );

  modport tx (
    input  cmd_stb, cmd_body,
    output tx_done
  );

  // Receiver takes the index echo from the command body
  modport rx (
    input  tx_done, rsp_kind, cmd_body,
    output rsp_done, rsp_err, rsp_data
  );

endinterface

// File: rtl/sd_cmd_layer.sv
`timescale 1ns/1ns

module sd_cmd_layer import sd_cmd_pkg::*; (
  input  logic           clk,
  input  logic           rst,

  input  logic           i_cmd_stb,
  input  logic [5:0]     i_cmd_idx,
  input  logic [31:0]    i_cmd_arg,

  output logic           o_busy,
  output logic           o_done,
  output sd_err_e        o_error,
  output logic [127:0]   o_rsp,

  sd_cmd_if.layer        cmd
);

  typedef enum logic [1:0] {IDLE, ISSUE, WAIT_RSP, REPORT} layer_state_e;

  layer_state_e state;
  logic         accept;

  // New commands are taken whenever the busy flag is low
  assign accept = i_cmd_stb && !o_busy;

  assign o_busy      = (state == ISSUE) || (state == WAIT_RSP);
  assign o_done      = (state == REPORT);
  assign cmd.cmd_stb = (state == ISSUE);

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE: begin
          if (accept) begin
            state <= ISSUE;
          end
        end
        ISSUE: begin
          state <= WAIT_RSP;
        end
        WAIT_RSP: begin
          if (cmd.rsp_done) begin
            state <= REPORT;
          end
        end
        REPORT: begin
          // Back to back command right after the done pulse
          if (accept) begin
            state <= ISSUE;
          end else begin
            state <= IDLE;
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  // Command body and response kind for the line side
  always_ff @(posedge clk) begin
    if (rst) begin
      cmd.rsp_kind <= RSP_NONE;
    end else if (accept) begin
      cmd.rsp_kind <= rsp_kind_of(i_cmd_idx);
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      cmd.cmd_body <= {2'b01, i_cmd_idx, i_cmd_arg};
    end
  end

  // Result capture
  always_ff @(posedge clk) begin
    if (rst) begin
      o_error <= ERR_NONE;
    end else if (state == WAIT_RSP && cmd.rsp_done) begin
      o_error <= cmd.rsp_err;
    end
  end

  always_ff @(posedge clk) begin
    if (state == WAIT_RSP && cmd.rsp_done) begin
      if (cmd.rsp_kind == RSP_LONG) begin
        // Drop start, transmission and index header byte
        o_rsp <= cmd.rsp_data[127:0];
      end else begin
        o_rsp <= {96'd0, cmd.rsp_data[39:8]};
      end
    end
  end

endmodule

// File: rtl/sd_cmd_tx.sv
`timescale 1ns/1ns

module sd_cmd_tx import sd_cmd_pkg::*, sd_crc_pkg::*; (
  input  logic   clk,
  input  logic   rst,

  sd_cmd_if.tx   tx,

  output logic   o_sd_cmd,
  output logic   o_sd_cmd_oe
);

  logic [39:0] shreg;
  logic [6:0]  crc;
  logic [5:0]  bit_cnt;

  // bit_cnt holds the number of frame bits already put on the line
  always_ff @(posedge clk) begin
    tx.tx_done <= 1'b0;
    if (rst) begin
      o_sd_cmd    <= 1'b1;
      o_sd_cmd_oe <= 1'b0;
      bit_cnt     <= '0;
      crc         <= '0;
      tx.tx_done  <= 1'b0;
    end else if (!o_sd_cmd_oe) begin
      if (tx.cmd_stb) begin
        // First body bit goes out right away
        o_sd_cmd    <= tx.cmd_body[39];
        o_sd_cmd_oe <= 1'b1;
        crc         <= crc7_step(7'd0, tx.cmd_body[39]);
        bit_cnt     <= 6'd1;
      end
    end else begin
      bit_cnt <= bit_cnt + 6'd1;
      if (bit_cnt < CMD_FRAME_LEN - 8) begin
        o_sd_cmd <= shreg[39];
        crc      <= crc7_step(crc, shreg[39]);
      end else if (bit_cnt < CMD_FRAME_LEN - 1) begin
        // CRC7 out MSB first
        o_sd_cmd <= crc[6];
        crc      <= {crc[5:0], 1'b0};
      end else if (bit_cnt == CMD_FRAME_LEN - 1) begin
        o_sd_cmd   <= 1'b1;
        tx.tx_done <= 1'b1;
      end else begin
        // Frame over, let the line float high
        o_sd_cmd    <= 1'b1;
        o_sd_cmd_oe <= 1'b0;
        bit_cnt     <= '0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!o_sd_cmd_oe && tx.cmd_stb) begin
      shreg <= {tx.cmd_body[38:0], 1'b0};
    end else if (o_sd_cmd_oe) begin
      shreg <= {shreg[38:0], 1'b0};
    end
  end

endmodule

// File: rtl/sd_rsp_rx.sv
`timescale 1ns/1ns

module sd_rsp_rx import sd_cmd_pkg::*, sd_crc_pkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [TIMEOUT_W-1:0]  i_timeout,
  input  logic                  i_sd_cmd,

  sd_cmd_if.rx                  rx
);

  typedef enum logic [1:0] {IDLE, WAIT_START, COLLECT, CHECK} rx_state_e;

  rx_state_e            state;
  rsp_kind_e            kind;
  logic [5:0]           idx_exp;
  logic [TIMEOUT_W-1:0] tcnt;
  logic [7:0]           pos;
  logic [7:0]           crc_top;
  logic [6:0]           crc;
  logic [135:0]         shreg;
  logic                 is_long;

  assign is_long = (kind == RSP_LONG);
  // Long CRC skips the 8-bit header
  assign crc_top = is_long ? 8'(RSP_LONG_LEN - 9) : 8'(RSP_SHORT_LEN - 1);

  always_ff @(posedge clk) begin
    rx.rsp_done <= 1'b0;
    if (rst) begin
      state       <= IDLE;
      kind        <= RSP_NONE;
      rx.rsp_done <= 1'b0;
      rx.rsp_err  <= ERR_NONE;
    end else begin
      case (state)
        IDLE: begin
          if (rx.tx_done) begin
            kind    <= rx.rsp_kind;
            idx_exp <= rx.cmd_body[37:32];
            tcnt    <= '0;
            if (rx.rsp_kind == RSP_NONE) begin
              rx.rsp_done <= 1'b1;
              rx.rsp_err  <= ERR_NONE;
            end else begin
              state <= WAIT_START;
            end
          end
        end
        WAIT_START: begin
          if (!i_sd_cmd) begin
            pos   <= is_long ? 8'(RSP_LONG_LEN - 2) : 8'(RSP_SHORT_LEN - 2);
            // Zero start bit leaves the CRC at zero
            crc   <= '0;
            state <= COLLECT;
          end else if (tcnt >= i_timeout) begin
            rx.rsp_done <= 1'b1;
            rx.rsp_err  <= ERR_TIMEOUT;
            state       <= IDLE;
          end else begin
            tcnt <= tcnt + 1'b1;
          end
        end
        COLLECT: begin
          if (pos >= 8'd8 && pos <= crc_top) begin
            crc <= crc7_step(crc, i_sd_cmd);
          end
          pos <= pos - 8'd1;
          if (pos == 8'd0) begin
            state <= CHECK;
          end
        end
        CHECK: begin
          rx.rsp_done <= 1'b1;
          state       <= IDLE;
          // First failing check wins
          if (!shreg[0]) begin
            rx.rsp_err <= ERR_END_BIT;
          end else if ((is_long ? shreg[133:128] : shreg[45:40]) !=
                       ((kind == RSP_SHORT) ? idx_exp : 6'h3f)) begin
            rx.rsp_err <= ERR_INDEX;
          end else if (kind != RSP_SHORT_NOCRC && shreg[7:1] != crc) begin
            rx.rsp_err <= ERR_CRC;
          end else begin
            rx.rsp_err <= ERR_NONE;
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  // Start bit lands in bit 0 of a cleared register
  always_ff @(posedge clk) begin
    if (state == WAIT_START && !i_sd_cmd) begin
      shreg <= '0;
    end else if (state == COLLECT) begin
      shreg <= {shreg[134:0], i_sd_cmd};
    end
  end

  assign rx.rsp_data = shreg;

endmodule

// File: rtl/sd_host_top.sv
`timescale 1ns/1ns

module sd_host_top import sd_cmd_pkg::*; (
  input  logic                  clk,
  input  logic                  rst,

  input  logic                  i_cmd_stb,
  input  logic [5:0]            i_cmd_idx,
  input  logic [31:0]           i_cmd_arg,
  input  logic [TIMEOUT_W-1:0]  i_timeout,
  output logic                  o_busy,
  output logic                  o_done,
  output sd_err_e               o_error,
  output logic [127:0]          o_rsp,

  // CMD line
  input  logic                  i_sd_cmd,
  output logic                  o_sd_cmd,
  output logic                  o_sd_cmd_oe
);

  sd_cmd_if cmd_bus ();

  sd_cmd_layer u_cmd_layer (
    .clk       (clk),
    .rst       (rst),
    .i_cmd_stb (i_cmd_stb),
    .i_cmd_idx (i_cmd_idx),
    .i_cmd_arg (i_cmd_arg),
    .o_busy    (o_busy),
    .o_done    (o_done),
    .o_error   (o_error),
    .o_rsp     (o_rsp),
    .cmd       (cmd_bus.layer)
  );

  sd_cmd_tx u_cmd_tx (
    .clk         (clk),
    .rst         (rst),
    .tx          (cmd_bus.tx),
    .o_sd_cmd    (o_sd_cmd),
    .o_sd_cmd_oe (o_sd_cmd_oe)
  );

  sd_rsp_rx u_rsp_rx (
    .clk       (clk),
    .rst       (rst),
    .i_timeout (i_timeout),
    .i_sd_cmd  (i_sd_cmd),
    .rx        (cmd_bus.rx)
  );

endmodule

// File: tb/sd_card_model.sv
`timescale 1ns/1ns

module sd_card_model (
  input  logic          clk,
  input  logic          i_host_cmd,
  input  logic          i_host_oe,
  input  int            i_delay,
  input  logic [31:0]   i_arg,
  input  logic [119:0]  i_payload,
  input  logic          i_bad_crc,
  input  logic          i_bad_idx,
  input  logic          i_bad_end,
  input  logic          i_silent,
  output logic          o_card_cmd,
  output logic [47:0]   o_frame,
  output int            o_frame_cnt
);

  // CRC7 over the low nbits of data, MSB first, x^7 + x^3 + 1
  function automatic logic [6:0] crc7_calc(input logic [119:0] data, input int nbits);
    logic [6:0] c;
    logic       fb;
    c = 7'd0;
    for (int i = nbits - 1; i >= 0; i--) begin
      fb = c[6] ^ data[i];
      c  = {c[5:0], 1'b0} ^ {3'b000, fb, 2'b00, fb};
    end
    return c;
  endfunction

  // len bits MSB first, one per clock, then release the line
  task automatic send_frame(input logic [135:0] bits, input int len);
    for (int i = len - 1; i >= 0; i--) begin
      @(posedge clk);
      #5;
      o_card_cmd = bits[i];
    end
    @(posedge clk);
    #5;
    o_card_cmd = 1'b1;
  endtask

  task automatic reply(input logic [5:0] idx);
    logic [39:0] body;
    logic [6:0]  crc;
    logic [5:0]  idx_tx;
    if (i_silent || idx == 6'd0) begin
      return;
    end
    repeat (i_delay) @(posedge clk);
    if (idx == 6'd2 || idx == 6'd9) begin
      crc = crc7_calc(i_payload, 120) ^ {6'd0, i_bad_crc};
      send_frame({2'b00, 6'h3f, i_payload, crc, ~i_bad_end}, 136);
    end else begin
      // R3 carries all ones in the index and CRC fields
      idx_tx = (idx == 6'd41) ? 6'h3f : (idx ^ {5'd0, i_bad_idx});
      body   = {2'b00, idx_tx, i_arg};
      crc    = (idx == 6'd41) ? 7'h7f : crc7_calc({80'd0, body}, 40);
      send_frame({88'd0, body, crc ^ {6'd0, i_bad_crc}, ~i_bad_end}, 48);
    end
  endtask

  initial begin
    int nbits;
    o_card_cmd  = 1'b1;
    o_frame     = '0;
    o_frame_cnt = 0;
    nbits       = 0;
    forever begin
      @(negedge clk);
      if (i_host_oe === 1'b1) begin
        o_frame = {o_frame[46:0], i_host_cmd};
        nbits   = nbits + 1;
        if (nbits == 48) begin
          nbits       = 0;
          o_frame_cnt = o_frame_cnt + 1;
          reply(o_frame[45:40]);
        end
      end
    end
  end

endmodule

// File: tb/tb_sd_host.sv
`timescale 1ns/1ns

module tb_sd_host import sd_cmd_pkg::*; ();

  logic          clk;
  logic          rst;
  logic          cmd_stb;
  logic [5:0]    cmd_idx;
  logic [31:0]   cmd_arg;
  logic [15:0]   rsp_timeout;
  logic          busy;
  logic          done;
  sd_err_e       error;
  logic [127:0]  rsp;
  logic          sd_cmd_in;
  logic          sd_cmd_out;
  logic          sd_cmd_oe;

  int            card_delay;
  logic [31:0]   card_arg;
  logic [119:0]  card_payload;
  logic          bad_crc;
  logic          bad_idx;
  logic          bad_end;
  logic          silent;
  logic [47:0]   frame;
  int            frame_cnt;

  int            errors;
  int            test_base;
  int            tests;
  int            tests_failed;
  logic [31:0]   lfsr_state;

  sd_host_top u_sd_host_top (
    .clk         (clk),
    .rst         (rst),
    .i_cmd_stb   (cmd_stb),
    .i_cmd_idx   (cmd_idx),
    .i_cmd_arg   (cmd_arg),
    .i_timeout   (rsp_timeout),
    .o_busy      (busy),
    .o_done      (done),
    .o_error     (error),
    .o_rsp       (rsp),
    .i_sd_cmd    (sd_cmd_in),
    .o_sd_cmd    (sd_cmd_out),
    .o_sd_cmd_oe (sd_cmd_oe)
  );

  sd_card_model u_card (
    .clk         (clk),
    .i_host_cmd  (sd_cmd_out),
    .i_host_oe   (sd_cmd_oe),
    .i_delay     (card_delay),
    .i_arg       (card_arg),
    .i_payload   (card_payload),
    .i_bad_crc   (bad_crc),
    .i_bad_idx   (bad_idx),
    .i_bad_end   (bad_end),
    .i_silent    (silent),
    .o_card_cmd  (sd_cmd_in),
    .o_frame     (frame),
    .o_frame_cnt (frame_cnt)
  );

  initial begin
    clk = 1'b0;
  end

  always #50 clk = ~clk;

  // Galois form, taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  task automatic draw_bits(input int n, output logic [127:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[126:0], lfsr_state[0]};
    end
  endtask

  function automatic logic [6:0] crc7_calc(input logic [119:0] data, input int nbits);
    logic [6:0] c;
    logic       fb;
    c = 7'd0;
    for (int i = nbits - 1; i >= 0; i--) begin
      fb = c[6] ^ data[i];
      c  = {c[5:0], 1'b0} ^ {3'b000, fb, 2'b00, fb};
    end
    return c;
  endfunction

  task automatic check_eq(input string name, input logic [127:0] exp, input logic [127:0] act);
    assert (act === exp) else begin
      errors++;
      $display("Mismatch at %0t: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  task automatic finish_test(input string name);
    tests++;
    if (errors == test_base) begin
      $display("Test %s: ok", name);
    end else begin
      tests_failed++;
      $display("Test %s: FAILED", name);
    end
    test_base = errors;
  endtask

  // Returns on the edge after the acceptance edge
  task automatic issue(input logic [5:0] idx, input logic [31:0] arg);
    @(posedge clk);
    #5;
    cmd_stb = 1'b1;
    cmd_idx = idx;
    cmd_arg = arg;
    @(posedge clk);
    #5;
    cmd_stb = 1'b0;
  endtask

  // Cycles counted from the acceptance edge
  task automatic wait_done(input int limit, output int cycles);
    cycles = 0;
    forever begin
      @(negedge clk);
      if (done) begin
        break;
      end
      cycles++;
      if (cycles > limit) begin
        errors++;
        $display("Timed out after %0d cycles waiting for o_done", limit);
        break;
      end
    end
  endtask

  task automatic run_short(input string name, input logic [5:0] idx, input sd_err_e exp);
    logic [127:0] r;
    int           cycles;
    draw_bits(32, r);
    card_arg = r[31:0];
    draw_bits(32, r);
    issue(idx, r[31:0]);
    wait_done(300, cycles);
    check_eq({name, " o_error"}, exp, error);
    if (exp == ERR_NONE) begin
      check_eq({name, " o_rsp"}, {96'd0, card_arg}, rsp);
    end
    finish_test(name);
  endtask

  // Host side of the CMD line idles high and busy never overlaps done
  always @(negedge clk) begin
    if (!rst) begin
      assert (sd_cmd_oe || sd_cmd_out) else begin
        errors++;
        $display("CMD line low at %0t while the host is not driving it", $time);
      end
      assert (!(busy && done)) else begin
        errors++;
        $display("o_busy and o_done both high at %0t", $time);
      end
    end
  end

  initial begin
    logic [127:0] r;
    logic [31:0]  arg;
    int           cycles;
    int           frames;
    int           dones;
    cmd_stb      = 1'b0;
    cmd_idx      = '0;
    cmd_arg      = '0;
    rsp_timeout  = 16'd200;
    rst          = 1'b1;
    card_delay   = 3;
    card_arg     = '0;
    card_payload = '0;
    bad_crc      = 1'b0;
    bad_idx      = 1'b0;
    bad_end      = 1'b0;
    silent       = 1'b0;
    errors       = 0;
    test_base    = 0;
    tests        = 0;
    tests_failed = 0;
    lfsr_state   = 32'hbdf4;
    repeat (16) @(posedge clk);
    #5;
    rst = 1'b0;
    @(negedge clk);
    check_eq("o_busy", 0, busy);
    check_eq("o_done", 0, done);
    check_eq("o_sd_cmd_oe", 0, sd_cmd_oe);
    check_eq("o_sd_cmd", 1, sd_cmd_out);
    check_eq("o_error", ERR_NONE, error);
    finish_test("reset");

    // No response, fixed latency
    draw_bits(32, r);
    arg = r[31:0];
    issue(6'd0, arg);
    wait_done(200, cycles);
    check_eq("cmd0 frame",
             {2'b01, 6'd0, arg, crc7_calc({80'd0, 2'b01, 6'd0, arg}, 40), 1'b1}, frame);
    check_eq("cmd0 done latency", 50, cycles);
    check_eq("cmd0 o_error", ERR_NONE, error);
    finish_test("cmd0");

    run_short("cmd8", 6'd8, ERR_NONE);

    // R2 with header byte removed
    card_delay = 6;
    draw_bits(120, r);
    card_payload = r[119:0];
    issue(6'd2, 32'd0);
    wait_done(400, cycles);
    check_eq("cmd2 o_error", ERR_NONE, error);
    check_eq("cmd2 o_rsp", {card_payload, crc7_calc(card_payload, 120), 1'b1}, rsp);
    finish_test("cmd2");
    card_delay = 3;

    bad_crc = 1'b1;
    run_short("bad_crc", 6'd7, ERR_CRC);
    bad_crc = 1'b0;
    bad_idx = 1'b1;
    run_short("bad_index", 6'd3, ERR_INDEX);
    bad_idx = 1'b0;
    bad_end = 1'b1;
    run_short("bad_end_bit", 6'd55, ERR_END_BIT);
    bad_end = 1'b0;
    run_short("acmd41", 6'd41, ERR_NONE);

    @(posedge clk);
    #5;
    silent      = 1'b1;
    rsp_timeout = 16'd40;
    issue(6'd8, 32'd0);
    wait_done(300, cycles);
    check_eq("timeout o_error", ERR_TIMEOUT, error);
    assert (cycles <= 100) else begin
      errors++;
      $display("o_done took %0d cycles after a timeout of 40", cycles);
    end
    finish_test("timeout");
    @(posedge clk);
    #5;
    silent      = 1'b0;
    rsp_timeout = 16'd200;

    // Second strobe lands while the first command is in flight
    frames = frame_cnt;
    issue(6'd8, 32'd1);
    @(posedge clk);
    #5;
    cmd_stb = 1'b1;
    cmd_idx = 6'd3;
    @(posedge clk);
    #5;
    cmd_stb = 1'b0;
    wait_done(300, cycles);
    check_eq("busy_strobe o_error", ERR_NONE, error);
    dones = 0;
    repeat (200) begin
      @(negedge clk);
      if (done) begin
        dones++;
      end
    end
    check_eq("extra o_done pulses", 0, dones);
    check_eq("frames sent", frames + 1, frame_cnt);
    finish_test("busy_strobe");

    $display("Tests run: %0d, tests failed: %0d, check errors: %0d",
             tests, tests_failed, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// File: flist.f
rtl/sd_cmd_pkg.sv
rtl/sd_crc_pkg.sv
rtl/sd_cmd_if.sv
rtl/sd_cmd_layer.sv
rtl/sd_cmd_tx.sv
rtl/sd_rsp_rx.sv
rtl/sd_host_top.sv
tb/sd_card_model.sv
tb/tb_sd_host.sv
